// File: hw/dsi_pkg.sv
// dsi packetizer package with lane types, dsi constants, fsm states, ecc and crc
package dsi_pkg;

  // --------------------------------------------------
  // lane and header field types
  // --------------------------------------------------
  typedef logic [7:0]  lane_byte_t;
  // four lanes side by side, lane 0 in bits 7:0
  typedef logic [31:0] lane_word_t;
  typedef logic [15:0] crc16_t;
  typedef logic [5:0]  data_type_t;
  typedef logic [15:0] word_count_t;
  typedef logic [1:0]  vc_t;
  typedef logic [7:0]  ecc_t;
  // request code on the packet type input
  typedef logic [2:0]  pkt_type_t;

  // request codes
  localparam pkt_type_t PKT_HSS = 3'd1;
  localparam pkt_type_t PKT_VSS = 3'd4;

  // dsi data types
  localparam data_type_t DT_HSYNC_START = 6'h21;
  localparam data_type_t DT_VSYNC_START = 6'h01;
  localparam data_type_t DT_RGB888      = 6'h3E;

  // leader byte on every lane before hs data
  localparam lane_byte_t HS_SYNC_BYTE = 8'hB8;
  localparam crc16_t     CRC_SEED     = 16'hFFFF;

  // --------------------------------------------------
  // fsm states
  // --------------------------------------------------
  typedef enum logic [1:0] {
    SHORT_IDLE,
    SHORT_SYNC,
    SHORT_HEADER
  } short_state_t;

  typedef enum logic [2:0] {
    LONG_IDLE,
    LONG_WAIT_GRANT,
    LONG_HEADER,
    LONG_FILL,
    LONG_PAYLOAD,
    LONG_CRC
  } long_state_t;

  // --------------------------------------------------
  // header ecc, hamming code over {wc, vc, dt}
  // --------------------------------------------------
  function automatic ecc_t ecc_calc(input logic [23:0] d);
    ecc_t e;
    // bits 7:6 are always zero in dsi
    e[7:6] = 2'b00;
    e[5]   = ^{d[23:21], d[19:10]};
    e[4]   = ^{d[23:22], d[20:16], d[9:4]};
    e[3]   = ^{d[23], d[21:19], d[15:13], d[9:7], d[3:1]};
    e[2]   = ^{d[22:20], d[18], d[15], d[12:11], d[9], d[6:5], d[3:2], d[0]};
    e[1]   = ^{d[23:20], d[17], d[14], d[12], d[10], d[8], d[6], d[4:3], d[1:0]};
    e[0]   = ^{d[23:20], d[16], d[13], d[11:10], d[7], d[5:4], d[2:0]};
    return e;
  endfunction

  // --------------------------------------------------
  // crc-16 x^16+x^12+x^5+1, one lane word per call
  // --------------------------------------------------
  function automatic crc16_t crc16_next_d32(input crc16_t crc, input lane_word_t data);
    crc16_t c;
    logic   fb;
    c = crc;
    // lane 0 bit 0 goes in first, lane 3 bit 7 last
    for (int i = 0; i < 32; i++) begin
      fb = c[15] ^ data[i];
      c  = {c[14:0], 1'b0} ^ ({16{fb}} & 16'h1021);
    end
    return c;
  endfunction

endpackage

// File: hw/hs_lane_if.sv
// request/grant lane bus between one packet source and the lane arbiter
`timescale 1ns/100ps

interface hs_lane_if
  import dsi_pkg::*;
();

  // source wants the lanes
  logic       req;
  // word taken at this edge
  logic       gnt;
  // four-lane word on offer
  lane_word_t word;
  // final word of the transmission, frees the lanes
  logic       last;

  modport src (output req, output word, output last, input gnt);

  modport arb (input req, input word, input last, output gnt);

endinterface

// File: hw/short_pkt_src.sv
// short packet source, sends the sync word then an hsync or vsync start header
`timescale 1ns/100ps

module short_pkt_src
  import dsi_pkg::*;
#(
  parameter vc_t VIRTUAL_CHANNEL = 2'd0
) (
  input  logic      I_lcd_clk,
  input  logic      I_rst_n,
  input  logic      tx_packet_flag,
  input  logic      tx_valid_data_flag,
  input  pkt_type_t tx_packet_type,
  hs_lane_if.src    bus,
  output logic      video_arm
);

  short_state_t state;
  data_type_t   dt_q;
  logic         is_hss;
  logic         is_vss;
  logic         accept;
  lane_byte_t   di_byte;
  ecc_t         ecc;

  // --------------------------------------------------
  // request decode
  // --------------------------------------------------
  assign is_hss = (tx_packet_type == PKT_HSS);
  assign is_vss = (tx_packet_type == PKT_VSS);
  // other types and requests while busy are dropped
  assign accept = tx_packet_flag && (state == SHORT_IDLE) && (is_hss || is_vss);

  // data id byte, channel in the top two bits
  assign di_byte = {VIRTUAL_CHANNEL, dt_q};
  // short packet word count is zero
  assign ecc     = ecc_calc({16'h0000, di_byte});

  // --------------------------------------------------
  // fsm
  // --------------------------------------------------
  always_ff @(posedge I_lcd_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      state     <= SHORT_IDLE;
      video_arm <= 1'b0;
    end else begin
      // hsync start with a line to follow starts the long source
      video_arm <= accept && is_hss && tx_valid_data_flag;
      case (state)
        SHORT_IDLE: begin
          if (accept) state <= SHORT_SYNC;
        end
        SHORT_SYNC: begin
          if (bus.gnt) state <= SHORT_HEADER;
        end
        SHORT_HEADER: begin
          if (bus.gnt) state <= SHORT_IDLE;
        end
        default: state <= SHORT_IDLE;
      endcase
    end
  end

  // data type held for the header cycle
  always_ff @(posedge I_lcd_clk) begin
    if (accept) dt_q <= is_hss ? DT_HSYNC_START : DT_VSYNC_START;
  end

  // --------------------------------------------------
  // lane bus
  // --------------------------------------------------
  always_comb begin
    bus.req  = 1'b0;
    bus.last = 1'b0;
    bus.word = '0;
    case (state)
      SHORT_SYNC: begin
        bus.req  = 1'b1;
        bus.word = {4{HS_SYNC_BYTE}};
      end
      SHORT_HEADER: begin
        // di on lane 0, ecc on lane 3
        bus.req  = 1'b1;
        bus.last = 1'b1;
        bus.word = {ecc, 8'h00, 8'h00, di_byte};
      end
      default: bus.req = 1'b0;
    endcase
  end

endmodule

// File: hw/long_pkt_src.sv
// long packet source, rgb888 header, zero fill, four-lane payload and crc-16
`timescale 1ns/100ps

module long_pkt_src
  import dsi_pkg::*;
#(
  parameter word_count_t LINE_BYTES      = 16'd5760,
  parameter vc_t         VIRTUAL_CHANNEL = 2'd0
) (
  input  logic       I_lcd_clk,
  input  logic       I_rst_n,
  input  logic       video_arm,
  input  logic       lcd_de,
  input  lane_word_t lcd_word,
  hs_lane_if.src     bus
);

  long_state_t state;
  // word on offer, header then fill, payload or crc
  lane_word_t  word_q;
  crc16_t      crc_q;
  lane_byte_t  di_byte;
  ecc_t        ecc;
  lane_word_t  hdr_word;

  // --------------------------------------------------
  // packet header
  // --------------------------------------------------
  assign di_byte  = {VIRTUAL_CHANNEL, DT_RGB888};
  assign ecc      = ecc_calc({LINE_BYTES, di_byte});
  // di, wc low, wc high, ecc from lane 0 up
  assign hdr_word = {ecc, LINE_BYTES[15:8], LINE_BYTES[7:0], di_byte};

  // --------------------------------------------------
  // fsm
  // --------------------------------------------------
  always_ff @(posedge I_lcd_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      state <= LONG_IDLE;
    end else begin
      case (state)
        LONG_IDLE: begin
          if (video_arm) state <= LONG_HEADER;
        end
        // header loaded into word_q this cycle
        LONG_HEADER: state <= LONG_WAIT_GRANT;
        // short packet still owns the lanes
        LONG_WAIT_GRANT: begin
          if (bus.gnt) state <= lcd_de ? LONG_PAYLOAD : LONG_FILL;
        end
        // bus held from here on, payload never stalls
        LONG_FILL: begin
          if (lcd_de) state <= LONG_PAYLOAD;
        end
        LONG_PAYLOAD: begin
          if (!lcd_de) state <= LONG_CRC;
        end
        LONG_CRC: begin
          if (bus.gnt) state <= LONG_IDLE;
        end
        default: state <= LONG_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // offered word register
  // --------------------------------------------------
  always_ff @(posedge I_lcd_clk) begin
    case (state)
      LONG_HEADER: word_q <= hdr_word;
      LONG_WAIT_GRANT: begin
        // header taken, next is pixel data or blanking zeros
        if (bus.gnt) word_q <= lcd_de ? lcd_word : '0;
      end
      LONG_FILL: word_q <= lcd_de ? lcd_word : '0;
      LONG_PAYLOAD: begin
        // de fell, crc low byte on lane 0, high byte on lane 1
        word_q <= lcd_de ? lcd_word : {16'h0000, crc_q};
      end
      default: word_q <= word_q;
    endcase
  end

  // --------------------------------------------------
  // payload crc
  // --------------------------------------------------
  always_ff @(posedge I_lcd_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      crc_q <= CRC_SEED;
    end else if (lcd_de) begin
      crc_q <= crc16_next_d32(crc_q, lcd_word);
    end else begin
      // reseed between lines
      crc_q <= CRC_SEED;
    end
  end

  // --------------------------------------------------
  // lane bus
  // --------------------------------------------------
  assign bus.req  = (state == LONG_WAIT_GRANT) || (state == LONG_FILL) ||
                    (state == LONG_PAYLOAD) || (state == LONG_CRC);
  assign bus.last = (state == LONG_CRC);
  assign bus.word = word_q;

endmodule

// File: hw/hs_lane_arbiter.sv
// fixed-priority lane arbiter, registers the granted word onto the hs lanes
`timescale 1ns/100ps

module hs_lane_arbiter
  import dsi_pkg::*;
(
  input  logic       I_lcd_clk,
  input  logic       I_rst_n,
  hs_lane_if.arb     short_bus,
  hs_lane_if.arb     long_bus,
  output logic       hs_en,
  output lane_word_t hs_word
);

  // owner flags, held until the owner's last word
  logic own_short;
  logic own_long;
  logic gnt_short;
  logic gnt_long;

  // --------------------------------------------------
  // grant, owner first, then short before long
  // --------------------------------------------------
  always_comb begin
    gnt_short = 1'b0;
    gnt_long  = 1'b0;
    if (own_short) begin
      gnt_short = short_bus.req;
    end else if (own_long) begin
      gnt_long = long_bus.req;
    end else if (short_bus.req) begin
      gnt_short = 1'b1;
    end else begin
      gnt_long = long_bus.req;
    end
  end

  assign short_bus.gnt = gnt_short;
  assign long_bus.gnt  = gnt_long;

  // --------------------------------------------------
  // ownership and lane registers
  // --------------------------------------------------
  always_ff @(posedge I_lcd_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      own_short <= 1'b0;
      own_long  <= 1'b0;
      hs_en     <= 1'b0;
      hs_word   <= '0;
    end else begin
      if (gnt_short) own_short <= !short_bus.last;
      if (gnt_long) own_long <= !long_bus.last;
      // lanes idle at zero when nothing is granted
      hs_en   <= gnt_short || gnt_long;
      hs_word <= gnt_short ? short_bus.word :
                 gnt_long  ? long_bus.word  : '0;
    end
  end

endmodule

// File: hw/mipi_packetizer.sv
// dsi four-lane hs packetizer top, short and long packet sources on one lane bus
`timescale 1ns/100ps

module mipi_packetizer
  import dsi_pkg::*;
#(
  parameter word_count_t LINE_BYTES      = 16'd5760,
  parameter vc_t         VIRTUAL_CHANNEL = 2'd0
) (
  input  logic       I_lcd_clk,
  input  logic       I_rst_n,
  input  logic       I_lcd_de,
  input  lane_byte_t I_lcd_rgb_lane0,
  input  lane_byte_t I_lcd_rgb_lane1,
  input  lane_byte_t I_lcd_rgb_lane2,
  input  lane_byte_t I_lcd_rgb_lane3,
  input  pkt_type_t  I_lcd_tx_packet_type,
  input  logic       I_lcd_tx_valid_data_flag,
  input  logic       I_lcd_tx_packet_flag,
  output logic       O_hs_en,
  output lane_byte_t O_hs_rgb_lane0,
  output lane_byte_t O_hs_rgb_lane1,
  output lane_byte_t O_hs_rgb_lane2,
  output lane_byte_t O_hs_rgb_lane3
);

  lane_word_t lcd_word;
  lane_word_t hs_word;
  // hsync start with valid data, starts the video packet
  logic       video_arm;

  hs_lane_if short_bus ();
  hs_lane_if long_bus ();

  // lane 0 in the low byte
  assign lcd_word = {I_lcd_rgb_lane3, I_lcd_rgb_lane2, I_lcd_rgb_lane1, I_lcd_rgb_lane0};

  short_pkt_src #(
    .VIRTUAL_CHANNEL (VIRTUAL_CHANNEL)
  ) u_short_pkt_src (
    .I_lcd_clk          (I_lcd_clk),
    .I_rst_n            (I_rst_n),
    .tx_packet_flag     (I_lcd_tx_packet_flag),
    .tx_valid_data_flag (I_lcd_tx_valid_data_flag),
    .tx_packet_type     (I_lcd_tx_packet_type),
    .bus                (short_bus.src),
    .video_arm          (video_arm)
  );

  long_pkt_src #(
    .LINE_BYTES      (LINE_BYTES),
    .VIRTUAL_CHANNEL (VIRTUAL_CHANNEL)
  ) u_long_pkt_src (
    .I_lcd_clk (I_lcd_clk),
    .I_rst_n   (I_rst_n),
    .video_arm (video_arm),
    .lcd_de    (I_lcd_de),
    .lcd_word  (lcd_word),
    .bus       (long_bus.src)
  );

  hs_lane_arbiter u_hs_lane_arbiter (
    .I_lcd_clk (I_lcd_clk),
    .I_rst_n   (I_rst_n),
    .short_bus (short_bus.arb),
    .long_bus  (long_bus.arb),
    .hs_en     (O_hs_en),
    .hs_word   (hs_word)
  );

  // back out to per-lane bytes
  assign O_hs_rgb_lane0 = hs_word[7:0];
  assign O_hs_rgb_lane1 = hs_word[15:8];
  assign O_hs_rgb_lane2 = hs_word[23:16];
  assign O_hs_rgb_lane3 = hs_word[31:24];

endmodule

// File: testbench/tb_mipi_packetizer.sv
// testbench for the dsi hs packetizer, short packets, video line, crc and lane timing
`timescale 1ns/100ps

module tb_mipi_packetizer;

  // request codes and expected lane states {hs_en, lane3..lane0}
  localparam logic [2:0]  HSS_TYPE   = 3'd1;
  localparam logic [2:0]  VSS_TYPE   = 3'd4;
  localparam logic [2:0]  BAD_TYPE   = 3'd2;
  localparam logic [32:0] IDLE_STATE = {1'b0, 32'h0000_0000};
  localparam logic [32:0] SYNC_STATE = {1'b1, 32'hB8B8_B8B8};
  localparam logic [32:0] VSS_HDR    = {1'b1, 32'h0700_0001};
  localparam logic [32:0] HSS_HDR    = {1'b1, 32'h1200_0021};
  localparam logic [32:0] RGB_HDR    = {1'b1, 32'h3B16_803E};
  localparam logic [32:0] FILL_STATE = {1'b1, 32'h0000_0000};
  localparam int LINE_WORDS = 16;
  // about 90 cycles of tests, plenty of margin
  localparam int MAX_CYCLES = 400;
  // event bits in the input history
  localparam int EV_SYNC  = 0;
  localparam int EV_HSS   = 1;
  localparam int EV_VSS   = 2;
  localparam int EV_END   = 3;
  localparam int EV_VID   = 4;
  localparam int EV_BLANK = 5;
  localparam int EV_DE    = 6;

  logic        I_lcd_clk;
  logic        I_rst_n;
  logic        I_lcd_de;
  logic [7:0]  I_lcd_rgb_lane0;
  logic [7:0]  I_lcd_rgb_lane1;
  logic [7:0]  I_lcd_rgb_lane2;
  logic [7:0]  I_lcd_rgb_lane3;
  logic [2:0]  I_lcd_tx_packet_type;
  logic        I_lcd_tx_valid_data_flag;
  logic        I_lcd_tx_packet_flag;
  logic        O_hs_en;
  logic [7:0]  O_hs_rgb_lane0;
  logic [7:0]  O_hs_rgb_lane1;
  logic [7:0]  O_hs_rgb_lane2;
  logic [7:0]  O_hs_rgb_lane3;

  // no transmission expected while high
  logic        quiet;
  // video line armed, no pixel word driven yet
  logic        blank;
  // request flag seen with a supported type
  logic        hss_req;
  logic        vss_req;
  logic [15:0] exp_crc;
  logic [31:0] in_word;
  logic [32:0] out_state;
  logic [6:0]  ev;
  logic [5:1][6:0]  ev_hist;
  logic [2:1][31:0] word_hist;
  string       test_name;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;
  int          seed;

  mipi_packetizer u_mipi_packetizer (
    .I_lcd_clk                (I_lcd_clk),
    .I_rst_n                  (I_rst_n),
    .I_lcd_de                 (I_lcd_de),
    .I_lcd_rgb_lane0          (I_lcd_rgb_lane0),
    .I_lcd_rgb_lane1          (I_lcd_rgb_lane1),
    .I_lcd_rgb_lane2          (I_lcd_rgb_lane2),
    .I_lcd_rgb_lane3          (I_lcd_rgb_lane3),
    .I_lcd_tx_packet_type     (I_lcd_tx_packet_type),
    .I_lcd_tx_valid_data_flag (I_lcd_tx_valid_data_flag),
    .I_lcd_tx_packet_flag     (I_lcd_tx_packet_flag),
    .O_hs_en                  (O_hs_en),
    .O_hs_rgb_lane0           (O_hs_rgb_lane0),
    .O_hs_rgb_lane1           (O_hs_rgb_lane1),
    .O_hs_rgb_lane2           (O_hs_rgb_lane2),
    .O_hs_rgb_lane3           (O_hs_rgb_lane3)
  );

  initial begin
    I_lcd_clk = 1'b0;
    forever #20 I_lcd_clk = ~I_lcd_clk;
  end

  assign in_word   = {I_lcd_rgb_lane3, I_lcd_rgb_lane2, I_lcd_rgb_lane1, I_lcd_rgb_lane0};
  assign out_state = {O_hs_en, O_hs_rgb_lane3, O_hs_rgb_lane2, O_hs_rgb_lane1, O_hs_rgb_lane0};

  // --------------------------------------------------
  // input history, ev_hist[k] is the input k edges back
  // --------------------------------------------------
  assign hss_req      = I_lcd_tx_packet_flag && (I_lcd_tx_packet_type == HSS_TYPE);
  assign vss_req      = I_lcd_tx_packet_flag && (I_lcd_tx_packet_type == VSS_TYPE);
  assign ev[EV_HSS]   = hss_req;
  assign ev[EV_VSS]   = vss_req;
  assign ev[EV_SYNC]  = hss_req || vss_req;
  // short packet with nothing behind it
  assign ev[EV_END]   = vss_req || (hss_req && !I_lcd_tx_valid_data_flag);
  assign ev[EV_VID]   = hss_req && I_lcd_tx_valid_data_flag;
  assign ev[EV_BLANK] = blank;
  assign ev[EV_DE]    = I_lcd_de;

  always_ff @(posedge I_lcd_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      ev_hist   <= '0;
      word_hist <= '0;
    end else begin
      ev_hist   <= {ev_hist[4:1], ev};
      word_hist <= {word_hist[1], in_word};
    end
  end

  // --------------------------------------------------
  // checks, lanes registered two edges after the input
  // --------------------------------------------------
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    quiet |-> out_state == IDLE_STATE)
    else report_value("idle lanes", IDLE_STATE, $sampled(out_state));
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    ev_hist[2][EV_SYNC] |-> out_state == SYNC_STATE)
    else report_value("sync word", SYNC_STATE, $sampled(out_state));
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    ev_hist[3][EV_HSS] |-> out_state == HSS_HDR)
    else report_value("hsync header", HSS_HDR, $sampled(out_state));
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    ev_hist[3][EV_VSS] |-> out_state == VSS_HDR)
    else report_value("vsync header", VSS_HDR, $sampled(out_state));
  // hs_en drops right after a lone short packet
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    ev_hist[4][EV_END] |-> out_state == IDLE_STATE)
    else report_value("short end", IDLE_STATE, $sampled(out_state));
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    ev_hist[4][EV_VID] |-> out_state == RGB_HDR)
    else report_value("rgb header", RGB_HDR, $sampled(out_state));
  // zero fill between the long header and the first pixel word
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    ev_hist[2][EV_BLANK] && ev_hist[5][EV_BLANK] |-> out_state == FILL_STATE)
    else report_value("zero fill", FILL_STATE, $sampled(out_state));
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    ev_hist[2][EV_DE] |-> out_state == {1'b1, word_hist[2]})
    else report_value("payload", $sampled({1'b1, word_hist[2]}), $sampled(out_state));
  // crc word right after the last payload word
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    ev_hist[3][EV_DE] && !ev_hist[2][EV_DE] |-> out_state == {1'b1, 16'h0000, exp_crc})
    else report_value("crc word", $sampled({1'b1, 16'h0000, exp_crc}), $sampled(out_state));
  assert property (@(posedge I_lcd_clk) disable iff (!I_rst_n)
    ev_hist[4][EV_DE] && !ev_hist[3][EV_DE] |-> out_state == IDLE_STATE)
    else report_value("long end", IDLE_STATE, $sampled(out_state));

  // run limit
  always @(posedge I_lcd_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic report_value(input string check, input logic [32:0] exp,
                              input logic [32:0] act);
    $display("[FAIL] %s %s: expected en=%b lanes=%h, actual en=%b lanes=%h",
             test_name, check, exp[32], exp[31:0], act[32], act[31:0]);
    test_errs  = test_errs + 1;
    total_errs = total_errs + 1;
  endtask

  // serial lfsr, taps at 0, 5 and 12, lane 0 bit 0 first
  function automatic logic [15:0] serial_crc16(input logic [15:0] crc,
                                               input logic [31:0] word);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int lane = 0; lane < 4; lane++) begin
      for (int b = 0; b < 8; b++) begin
        fb = c[15] ^ word[8 * lane + b];
        c  = {c[14:12], c[11] ^ fb, c[10:5], c[4] ^ fb, c[3:0], fb};
      end
    end
    return c;
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test;
    tests_run = tests_run + 1;
    if (test_errs != 0) tests_failed = tests_failed + 1;
    $display("test %-14s %s (%0d errors)", test_name, test_errs == 0 ? "ok" : "bad",
             test_errs);
  endtask

  // wait for hs_en to rise and fall, sampled away from the clock edge
  task automatic wait_tx_done;
    @(negedge I_lcd_clk);
    while (!O_hs_en) @(negedge I_lcd_clk);
    while (O_hs_en) @(negedge I_lcd_clk);
    // let the end-of-transmission checks fire
    repeat (3) @(posedge I_lcd_clk);
  endtask

  task automatic send_short(input logic [2:0] ptype, input logic valid);
    @(posedge I_lcd_clk);
    I_lcd_tx_packet_flag     <= 1'b1;
    I_lcd_tx_packet_type     <= ptype;
    I_lcd_tx_valid_data_flag <= valid;
    @(posedge I_lcd_clk);
    I_lcd_tx_packet_flag     <= 1'b0;
    I_lcd_tx_valid_data_flag <= 1'b0;
    wait_tx_done();
  endtask

  task automatic send_video_line;
    logic [31:0] rnd;
    logic [15:0] crc;
    crc = 16'hFFFF;
    @(posedge I_lcd_clk);
    I_lcd_tx_packet_flag     <= 1'b1;
    I_lcd_tx_packet_type     <= HSS_TYPE;
    I_lcd_tx_valid_data_flag <= 1'b1;
    blank                    <= 1'b1;
    @(posedge I_lcd_clk);
    I_lcd_tx_packet_flag     <= 1'b0;
    I_lcd_tx_valid_data_flag <= 1'b0;
    // blanking before the first pixel word
    repeat (4) @(posedge I_lcd_clk);
    for (int i = 0; i < LINE_WORDS; i++) begin
      @(posedge I_lcd_clk);
      rnd = $random(seed);
      crc = serial_crc16(crc, rnd);
      I_lcd_de        <= 1'b1;
      I_lcd_rgb_lane0 <= rnd[7:0];
      I_lcd_rgb_lane1 <= rnd[15:8];
      I_lcd_rgb_lane2 <= rnd[23:16];
      I_lcd_rgb_lane3 <= rnd[31:24];
      blank           <= 1'b0;
      exp_crc         <= crc;
    end
    @(posedge I_lcd_clk);
    I_lcd_de        <= 1'b0;
    I_lcd_rgb_lane0 <= 8'h00;
    I_lcd_rgb_lane1 <= 8'h00;
    I_lcd_rgb_lane2 <= 8'h00;
    I_lcd_rgb_lane3 <= 8'h00;
    wait_tx_done();
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    I_rst_n                  = 1'b0;
    I_lcd_de                 = 1'b0;
    I_lcd_rgb_lane0          = 8'h00;
    I_lcd_rgb_lane1          = 8'h00;
    I_lcd_rgb_lane2          = 8'h00;
    I_lcd_rgb_lane3          = 8'h00;
    I_lcd_tx_packet_type     = 3'd0;
    I_lcd_tx_valid_data_flag = 1'b0;
    I_lcd_tx_packet_flag     = 1'b0;
    quiet        = 1'b0;
    blank        = 1'b0;
    exp_crc      = 16'hFFFF;
    test_name    = "reset";
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_count  = 0;
    seed         = 27;
    repeat (3) @(posedge I_lcd_clk);
    I_rst_n <= 1'b1;

    begin_test("reset_idle");
    @(posedge I_lcd_clk);
    quiet <= 1'b1;
    repeat (6) @(posedge I_lcd_clk);
    quiet <= 1'b0;
    @(posedge I_lcd_clk);
    end_test();

    begin_test("vsync_start");
    send_short(VSS_TYPE, 1'b0);
    end_test();

    begin_test("hsync_start");
    send_short(HSS_TYPE, 1'b0);
    end_test();

    // header, fill, payload and crc of one line
    begin_test("video_line");
    send_video_line();
    end_test();

    begin_test("bad_type");
    @(posedge I_lcd_clk);
    quiet <= 1'b1;
    @(posedge I_lcd_clk);
    I_lcd_tx_packet_flag <= 1'b1;
    I_lcd_tx_packet_type <= BAD_TYPE;
    @(posedge I_lcd_clk);
    I_lcd_tx_packet_flag <= 1'b0;
    repeat (6) @(posedge I_lcd_clk);
    quiet <= 1'b0;
    @(posedge I_lcd_clk);
    end_test();

    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, total_errs);
    if (total_errs == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: mipi_packetizer.f
hw/dsi_pkg.sv
hw/hs_lane_if.sv
hw/short_pkt_src.sv
hw/long_pkt_src.sv
hw/hs_lane_arbiter.sv
hw/mipi_packetizer.sv
testbench/tb_mipi_packetizer.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench and the dut with verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f mipi_packetizer.f --top-module tb_mipi_packetizer -o sim_mipi_packetizer \
  && ./obj_dir/sim_mipi_packetizer > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log \
  && { echo "simulation reported a failure"; exit 1; } \
  || { echo "simulation finished clean"; exit 0; }
